// ==== Bender.yml ====
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_tag_store.sv
  - dcache_data_store.sv
  - dcache_repl_state.sv
  - dcache_ctrl.sv
  - dcache.sv
  - target: test
    files:
      - dcache_tb.sv

// ==== dcache.f ====
dcache_pkg.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_repl_state.sv
dcache_ctrl.sv
dcache.sv
dcache_tb.sv

// ==== dcache.sv ====
module dcache
    import dcache_pkg::*;
#(
    parameter int SETS_LOG2 = 6
) (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      req_valid_i,
    input  core_req_t req_i,
    output logic      ready_o,
    output logic      done_o,
    output word_t     rdata_o,
    output mem_req_t  mem_req_o,
    input  logic      mem_ready_i,
    input  word_t     mem_rdata_i
);

    localparam int TAG_W = ADDR_W - OFFSET_W - SETS_LOG2;

    logic [SETS_LOG2-1:0]  index;
    logic                  tag_we;
    way_t                  tag_way;
    logic [TAG_W-1:0]      tag_wr;
    logic [1:0]            tag_valid;
    logic [1:0][TAG_W-1:0] tag_rd;
    logic                  data_we;
    way_t                  data_way;
    word_t                 data_wdata;
    strb_t                 data_mask;
    word_t [1:0]           data_rd;
    logic                  touch;
    way_t                  touch_way;
    logic                  set_dirty;
    logic                  clear_dirty;
    way_t                  victim_way;
    logic                  victim_dirty;

    dcache_ctrl #(
        .SETS_LOG2(SETS_LOG2)
    ) ctrl_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .req_valid_i   (req_valid_i),
        .req_i         (req_i),
        .ready_o       (ready_o),
        .done_o        (done_o),
        .rdata_o       (rdata_o),
        .mem_req_o     (mem_req_o),
        .mem_ready_i   (mem_ready_i),
        .mem_rdata_i   (mem_rdata_i),
        .index_o       (index),
        .tag_we_o      (tag_we),
        .tag_way_o     (tag_way),
        .tag_o         (tag_wr),
        .tag_valid_i   (tag_valid),
        .tag_i         (tag_rd),
        .data_we_o     (data_we),
        .data_way_o    (data_way),
        .data_wdata_o  (data_wdata),
        .data_mask_o   (data_mask),
        .data_rdata_i  (data_rd),
        .touch_o       (touch),
        .touch_way_o   (touch_way),
        .set_dirty_o   (set_dirty),
        .clear_dirty_o (clear_dirty),
        .victim_way_i  (victim_way),
        .victim_dirty_i(victim_dirty)
    );

    dcache_tag_store #(
        .SETS_LOG2(SETS_LOG2)
    ) tag_store_i (
        .clk    (clk),
        .rst_i  (rst_i),
        .index_i(index),
        .we_i   (tag_we),
        .way_i  (tag_way),
        .tag_i  (tag_wr),
        .valid_o(tag_valid),
        .tag0_o (tag_rd[0]),
        .tag1_o (tag_rd[1])
    );

    dcache_data_store #(
        .SETS_LOG2(SETS_LOG2)
    ) data_store_i (
        .clk     (clk),
        .index_i (index),
        .we_i    (data_we),
        .way_i   (data_way),
        .wdata_i (data_wdata),
        .mask_i  (data_mask),
        .rdata0_o(data_rd[0]),
        .rdata1_o(data_rd[1])
    );

    dcache_repl_state #(
        .SETS_LOG2(SETS_LOG2)
    ) repl_state_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .index_i       (index),
        .touch_i       (touch),
        .touch_way_i   (touch_way),
        .set_dirty_i   (set_dirty),
        .clear_dirty_i (clear_dirty),
        .victim_way_o  (victim_way),
        .victim_dirty_o(victim_dirty)
    );

endmodule

// ==== dcache_ctrl.sv ====
module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter  int SETS_LOG2 = 6,
    localparam int TAG_W     = ADDR_W - OFFSET_W - SETS_LOG2
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  req_valid_i,
    input  core_req_t             req_i,
    output logic                  ready_o,
    output logic                  done_o,
    output word_t                 rdata_o,
    output mem_req_t              mem_req_o,
    input  logic                  mem_ready_i,
    input  word_t                 mem_rdata_i,
    output logic [SETS_LOG2-1:0]  index_o,
    output logic                  tag_we_o,
    output way_t                  tag_way_o,
    output logic [TAG_W-1:0]      tag_o,
    input  logic [1:0]            tag_valid_i,
    input  logic [1:0][TAG_W-1:0] tag_i,
    output logic                  data_we_o,
    output way_t                  data_way_o,
    output word_t                 data_wdata_o,
    output strb_t                 data_mask_o,
    input  word_t [1:0]           data_rdata_i,
    output logic                  touch_o,
    output way_t                  touch_way_o,
    output logic                  set_dirty_o,
    output logic                  clear_dirty_o,
    input  way_t                  victim_way_i,
    input  logic                  victim_dirty_i
);

    ctrl_state_e      state_q;
    ctrl_state_e      state_d;
    logic [TAG_W-1:0] req_tag;
    logic [1:0]       hit;
    way_t             hit_way;
    logic             victim_valid;
    logic             refill_done;
    logic             hit_write;

    // request is held by the core until done_o
    assign index_o = req_i.addr[OFFSET_W +: SETS_LOG2];
    assign req_tag = req_i.addr[ADDR_W-1 -: TAG_W];

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = tag_valid_i[w] && (tag_i[w] == req_tag);
        end
    end

    // at most one way can match
    assign hit_way      = hit[1];
    assign victim_valid = tag_valid_i[victim_way_i];

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (req_valid_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (|hit) begin
                    state_d = ST_HIT;
                end else if (victim_valid && victim_dirty_i) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_REFILL;
                end
            end
            ST_HIT: state_d = ST_IDLE;
            ST_WRITEBACK: begin
                if (mem_ready_i) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                // back to lookup, which then hits
                if (mem_ready_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            done_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_o  <= (state_q == ST_HIT);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_HIT) begin
            rdata_o <= data_rdata_i[hit_way];
        end
    end

    assign ready_o     = (state_q == ST_IDLE);
    assign refill_done = (state_q == ST_REFILL) && mem_ready_i;
    assign hit_write   = (state_q == ST_HIT) && req_i.write;

    // refill fills the whole victim line, a write hit merges by strobe
    assign tag_we_o      = refill_done;
    assign tag_way_o     = victim_way_i;
    assign tag_o         = req_tag;
    assign data_we_o     = refill_done || hit_write;
    assign data_way_o    = refill_done ? victim_way_i : hit_way;
    assign data_wdata_o  = refill_done ? mem_rdata_i : req_i.wdata;
    assign data_mask_o   = refill_done ? '1 : req_i.wstrb;
    assign touch_o       = (state_q == ST_HIT);
    assign touch_way_o   = hit_way;
    assign set_dirty_o   = hit_write;
    assign clear_dirty_o = refill_done;

    always_comb begin
        mem_req_o.cmd  = MEM_NONE;
        mem_req_o.addr = '0;
        mem_req_o.data = data_rdata_i[victim_way_i];
        case (state_q)
            ST_WRITEBACK: begin
                mem_req_o.cmd  = MEM_WRITEBACK;
                mem_req_o.addr = {tag_i[victim_way_i], index_o, {OFFSET_W{1'b0}}};
            end
            ST_REFILL: begin
                mem_req_o.cmd  = MEM_REFILL;
                mem_req_o.addr = {req_tag, index_o, {OFFSET_W{1'b0}}};
            end
            default: ;
        endcase
    end

endmodule

// ==== dcache_data_store.sv ====
module dcache_data_store
    import dcache_pkg::*;
#(
    parameter int SETS_LOG2 = 6
) (
    input  logic                 clk,
    input  logic [SETS_LOG2-1:0] index_i,
    input  logic                 we_i,
    input  way_t                 way_i,
    input  word_t                wdata_i,
    input  strb_t                mask_i,
    output word_t                rdata0_o,
    output word_t                rdata1_o
);

    localparam int SETS = 2 ** SETS_LOG2;

    word_t mem_q [2][SETS];
    word_t merged;

    // bytes outside the mask keep the stored value
    always_comb begin
        merged = mem_q[way_i][index_i];
        for (int b = 0; b < STRB_W; b++) begin
            if (mask_i[b]) begin
                merged[8*b +: 8] = wdata_i[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[way_i][index_i] <= merged;
        end
        // write-first, so a refilled line reads back on the next cycle
        rdata0_o <= (we_i && way_i == 1'b0) ? merged : mem_q[0][index_i];
        rdata1_o <= (we_i && way_i == 1'b1) ? merged : mem_q[1][index_i];
    end

endmodule

// ==== dcache_pkg.sv ====
package dcache_pkg;

    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 3;
    localparam int WORD_W   = 64;
    localparam int STRB_W   = WORD_W / 8;
    localparam int AGE_W    = 3;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic              way_t;
    typedef logic [AGE_W-1:0]  age_t;

    // ages saturate here
    localparam age_t AGE_MAX = '1;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        strb_t wstrb;
        logic  write;
    } core_req_t;

    typedef enum logic [1:0] {
        MEM_NONE      = 2'd0,
        MEM_WRITEBACK = 2'd1,
        MEM_REFILL    = 2'd2
    } mem_cmd_e;

    // addr is word-aligned, data only matters for a write-back
    typedef struct packed {
        mem_cmd_e cmd;
        addr_t    addr;
        word_t    data;
    } mem_req_t;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LOOKUP    = 3'd1,
        ST_HIT       = 3'd2,
        ST_WRITEBACK = 3'd3,
        ST_REFILL    = 3'd4
    } ctrl_state_e;

endpackage

// ==== dcache_repl_state.sv ====
module dcache_repl_state
    import dcache_pkg::*;
#(
    parameter int SETS_LOG2 = 6
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic [SETS_LOG2-1:0] index_i,
    input  logic                 touch_i,
    input  way_t                 touch_way_i,
    input  logic                 set_dirty_i,
    input  logic                 clear_dirty_i,
    output way_t                 victim_way_o,
    output logic                 victim_dirty_o
);

    localparam int SETS = 2 ** SETS_LOG2;

    age_t [SETS-1:0][1:0] age_q;
    logic [SETS-1:0][1:0] dirty_q;
    age_t                 age0;
    age_t                 age1;
    way_t                 other_way;

    assign age0      = age_q[index_i][0];
    assign age1      = age_q[index_i][1];
    assign other_way = ~touch_way_i;

    // older way goes, way 0 on a tie
    assign victim_way_o   = (age1 > age0);
    assign victim_dirty_o = dirty_q[index_i][victim_way_o];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            age_q   <= '0;
            dirty_q <= '0;
        end else begin
            if (touch_i) begin
                age_q[index_i][touch_way_i] <= '0;
                if (age_q[index_i][other_way] != AGE_MAX) begin
                    age_q[index_i][other_way] <= age_q[index_i][other_way] + 1'b1;
                end
            end
            if (set_dirty_i) begin
                dirty_q[index_i][touch_way_i] <= 1'b1;
            end
            if (clear_dirty_i) begin
                dirty_q[index_i][victim_way_o] <= 1'b0;
            end
        end
    end

endmodule

// ==== dcache_tag_store.sv ====
module dcache_tag_store
    import dcache_pkg::*;
#(
    parameter  int SETS_LOG2 = 6,
    localparam int TAG_W     = ADDR_W - OFFSET_W - SETS_LOG2
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic [SETS_LOG2-1:0] index_i,
    input  logic                 we_i,
    input  way_t                 way_i,
    input  logic [TAG_W-1:0]     tag_i,
    output logic [1:0]           valid_o,
    output logic [TAG_W-1:0]     tag0_o,
    output logic [TAG_W-1:0]     tag1_o
);

    localparam int SETS = 2 ** SETS_LOG2;

    logic [SETS-1:0][1:0] valid_q;
    logic [TAG_W-1:0]     tag_q [2][SETS];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
            valid_o <= '0;
        end else begin
            valid_o <= valid_q[index_i];
            // a write shows up on the read port at once
            if (we_i) begin
                valid_q[index_i][way_i] <= 1'b1;
                valid_o[way_i]          <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_q[way_i][index_i] <= tag_i;
        end
        tag0_o <= (we_i && way_i == 1'b0) ? tag_i : tag_q[0][index_i];
        tag1_o <= (we_i && way_i == 1'b1) ? tag_i : tag_q[1][index_i];
    end

endmodule

// ==== dcache_tb.sv ====
module dcache_tb;
    import dcache_pkg::*;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SETS_LOG2  = 6;
    localparam int SETS       = 2 ** SETS_LOG2;
    localparam int TAG_W      = ADDR_W - OFFSET_W - SETS_LOG2;
    localparam int N_REQ      = 400;
    localparam int MAX_CYCLES = N_REQ * 20;

    logic      clk;
    logic      rst_i;
    logic      req_valid_i;
    core_req_t req_i;
    logic      ready_o;
    logic      done_o;
    word_t     rdata_o;
    mem_req_t  mem_req_o;
    logic      mem_ready_i;
    word_t     mem_rdata_i;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     cycle_count = 0;

    // unwritten words of the memory model come from fill_word
    word_t mem_words [addr_t];

    // reference copy of the cache state
    logic             m_valid [SETS][2];
    logic [TAG_W-1:0] m_tag   [SETS][2];
    logic             m_dirty [SETS][2];
    age_t             m_age   [SETS][2];
    word_t            m_data  [SETS][2];

    // memory requests the model expects, in order
    mem_cmd_e exp_cmd  [$];
    addr_t    exp_addr [$];
    word_t    exp_data [$];

    dcache #(
        .SETS_LOG2(SETS_LOG2)
    ) dut_i (
        .clk        (clk),
        .rst_i      (rst_i),
        .req_valid_i(req_valid_i),
        .req_i      (req_i),
        .ready_o    (ready_o),
        .done_o     (done_o),
        .rdata_o    (rdata_o),
        .mem_req_o  (mem_req_o),
        .mem_ready_i(mem_ready_i),
        .mem_rdata_i(mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("error: run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d, checks: %0d", errors + 1, checks);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic word_t fill_word(addr_t a);
        return {~a, a ^ {a[15:0], a[31:16]}};
    endfunction

    function automatic word_t mem_read(addr_t a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return fill_word(a);
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // updates the model and queues the memory traffic a request should cause
    task automatic predict(input core_req_t r, output logic was_hit, output word_t exp_rd);
        logic [SETS_LOG2-1:0] idx;
        logic [TAG_W-1:0]     tag;
        addr_t                line_addr;
        addr_t                wb_addr;
        int                   h;
        idx = r.addr[OFFSET_W +: SETS_LOG2];
        tag = r.addr[ADDR_W-1 -: TAG_W];
        line_addr = {tag, idx, {OFFSET_W{1'b0}}};
        was_hit = 1'b0;
        h = 0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                was_hit = 1'b1;
                h = w;
            end
        end
        if (!was_hit) begin
            // older way is replaced, way 0 on a tie
            h = (m_age[idx][1] > m_age[idx][0]) ? 1 : 0;
            if (m_valid[idx][h] && m_dirty[idx][h]) begin
                wb_addr = {m_tag[idx][h], idx, {OFFSET_W{1'b0}}};
                exp_cmd.push_back(MEM_WRITEBACK);
                exp_addr.push_back(wb_addr);
                exp_data.push_back(m_data[idx][h]);
                mem_words[wb_addr] = m_data[idx][h];
            end
            exp_cmd.push_back(MEM_REFILL);
            exp_addr.push_back(line_addr);
            exp_data.push_back(mem_read(line_addr));
            m_valid[idx][h] = 1'b1;
            m_tag[idx][h]   = tag;
            m_dirty[idx][h] = 1'b0;
            m_data[idx][h]  = mem_read(line_addr);
        end
        m_age[idx][h] = '0;
        if (m_age[idx][1-h] != 3'd7) begin
            m_age[idx][1-h] = m_age[idx][1-h] + 1'b1;
        end
        if (r.write) begin
            m_data[idx][h]  = merge_bytes(m_data[idx][h], r.wdata, r.wstrb);
            m_dirty[idx][h] = 1'b1;
        end
        exp_rd = m_data[idx][h];
    endtask

    task automatic check_mem_request();
        mem_cmd_e e_cmd;
        addr_t    e_addr;
        word_t    e_data;
        if (exp_cmd.size() == 0) begin
            errors++;
            $display("error: unexpected %s request to %h", mem_req_o.cmd.name(), mem_req_o.addr);
        end else begin
            e_cmd  = exp_cmd.pop_front();
            e_addr = exp_addr.pop_front();
            e_data = exp_data.pop_front();
            check_value("memory command", e_cmd, mem_req_o.cmd);
            check_value("memory address", e_addr, mem_req_o.addr);
            if (e_cmd == MEM_WRITEBACK) begin
                check_value("write-back data", e_data, mem_req_o.data);
            end
        end
    endtask

    // one request from drive to done, with the memory answering on the way
    task automatic run_request(input core_req_t r);
        logic  was_hit;
        word_t exp_rd;
        int    cycles;
        int    delay;
        logic  busy;
        predict(r, was_hit, exp_rd);
        if (!ready_o) begin
            errors++;
            $display("error: cache not ready for a new request");
        end
        req_i = r;
        req_valid_i = 1'b1;
        @(posedge clk);
        #1;
        if (ready_o) begin
            errors++;
            $display("error: cache still ready after accepting a request");
        end
        cycles = 0;
        busy = 1'b0;
        delay = 0;
        while (!done_o) begin
            @(posedge clk);
            #1;
            cycles++;
            mem_ready_i = 1'b0;
            if (!done_o && ready_o) begin
                errors++;
                $display("error: cache ready while a request is in flight");
            end
            if (!done_o && mem_req_o.cmd != MEM_NONE) begin
                if (!busy) begin
                    busy = 1'b1;
                    delay = $random(seed) & 3;
                    check_mem_request();
                end
                if (delay == 0) begin
                    mem_ready_i = 1'b1;
                    busy = 1'b0;
                    if (mem_req_o.cmd == MEM_REFILL) begin
                        mem_rdata_i = mem_read(mem_req_o.addr);
                    end
                end else begin
                    delay--;
                end
            end
        end
        req_valid_i = 1'b0;
        if (was_hit) begin
            check_value("hit latency", 2, cycles);
        end
        if (exp_cmd.size() != 0) begin
            errors++;
            $display("error: %0d expected memory requests never issued", exp_cmd.size());
            exp_cmd.delete();
            exp_addr.delete();
            exp_data.delete();
        end
        if (!r.write) begin
            check_value("read data", exp_rd, rdata_o);
        end
    endtask

    initial begin
        core_req_t   req;
        core_req_t   rd;
        logic [31:0] r;
        logic [31:0] r2;
        int          n;
        seed = 32'h6a10_a07c;
        rst_i = 1'b1;
        req_valid_i = 1'b0;
        req_i = '0;
        mem_ready_i = 1'b0;
        mem_rdata_i = '0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = '0;
                m_data[s][w]  = '0;
            end
        end
        repeat (2) @(posedge clk);
        #1;
        rst_i = 1'b0;
        check_value("ready after reset", 1, ready_o);
        check_value("done after reset", 0, done_o);
        check_value("memory command after reset", MEM_NONE, mem_req_o.cmd);
        n = 0;
        while (n < N_REQ) begin
            r = $random(seed);
            r2 = $random(seed);
            // 4 tags over 4 sets, so conflicts are frequent
            req.addr  = {TAG_W'(32'h155 + r[1:0]), SETS_LOG2'(r[3:2] * 13), r[6:4]};
            req.write = r[7];
            req.wstrb = r2[7:0];
            req.wdata = {$random(seed), $random(seed)};
            run_request(req);
            n++;
            if (req.write) begin
                rd = req;
                rd.write = 1'b0;
                run_request(rd);
                n++;
            end
        end
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
